// ==== source/copper_pkg.sv ====
// copper instruction format, opcodes, register-write and APB types shared by the coprocessor
package copper_pkg;

    // instruction kind, lives in the low two bits of the odd word
    typedef enum logic [1:0] {
        COP_WAIT = 2'd0,
        COP_MOVE = 2'd1,
        COP_JUMP = 2'd2,
        COP_END  = 2'd3
    } opcode_e;

    // even word on top, odd word below
    // WAIT: op_a line, op_b pixel
    // MOVE: op_a data, op_b[7:0] register address
    // JUMP: op_a target index
    typedef struct packed {
        logic [15:0] op_a;
        logic [13:0] op_b;
        opcode_e     opcode;
    } instr_t;

    // one display register write, no back-pressure
    typedef struct packed {
        logic        valid;
        logic [7:0]  addr;
        logic [15:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [15:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // host register map
    localparam logic [15:0] CTRL_ADDR   = 16'h0000;
    // read only, bit 0 running, bits 15:4 program counter
    localparam logic [15:0] STATUS_ADDR = 16'h0004;
    // program words at a 4 byte stride from here
    localparam logic [15:0] PROG_BASE   = 16'h1000;

endpackage

// ==== source/video_pkg.sv ====
// raster widths and beam position type shared by the beam counter, the copper and the top
package video_pkg;

    // horizontal pixel counter width
    localparam int H_WIDTH = 11;
    // vertical line counter width
    localparam int V_WIDTH = 10;

    typedef logic [H_WIDTH-1:0] beam_h_t;
    typedef logic [V_WIDTH-1:0] beam_v_t;

    // current raster position
    typedef struct packed {
        beam_h_t h;
        beam_v_t v;
    } beam_pos_t;

endpackage

// ==== source/copper_mem.sv ====
// one 16-bit half of the copper program memory, used twice side by side for a 32-bit word
`timescale 1ns/100ps

module copper_mem #(
    parameter int AWIDTH = 10,
    parameter bit EVEN   = 1'b1
) (
    input  logic              clk,
    input  logic [AWIDTH-1:0] rd_addr_i,
    output logic [15:0]       rd_data_o,
    input  logic              wr_en_i,
    input  logic [AWIDTH-1:0] wr_addr_i,
    input  logic [15:0]       wr_data_i
);

    // erased contents decode as END
    // even half carries operand A only, odd half holds the opcode
    localparam logic [15:0] ERASED = EVEN ? 16'h0000 : {14'b0, copper_pkg::COP_END};

    logic [15:0] bram [0:2**AWIDTH-1];

    // goes high after the first clock edge, the copper address is settled by then
    logic armed = 1'b0;

    initial begin
        for (int i = 0; i < 2**AWIDTH; i++) begin
            bram[i] = ERASED;
        end
    end

    // host write port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            bram[wr_addr_i] <= wr_data_i;
        end
    end

    // registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data_o <= bram[rd_addr_i];
    end

    always_ff @(posedge clk) begin
        armed <= 1'b1;
    end

    // the copper must always present a real address once its reset has applied
    a_rd_addr_known: assert property (@(posedge clk) armed |-> !$isunknown(rd_addr_i))
        else $error("copper memory read address unknown");

endmodule

// ==== source/beam_counter.sv ====
// raster beam counter, gives the pixel and line position and a frame start pulse
`timescale 1ns/100ps

module beam_counter #(
    parameter int H_TOTAL = 800,
    parameter int V_TOTAL = 525
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    output video_pkg::beam_pos_t beam_o,
    output logic                 frame_start_o
);

    // last pixel of a row and last line of a frame
    localparam video_pkg::beam_h_t H_LAST = video_pkg::beam_h_t'(H_TOTAL - 1);
    localparam video_pkg::beam_v_t V_LAST = video_pkg::beam_v_t'(V_TOTAL - 1);

    video_pkg::beam_pos_t beam_q;
    logic                 row_end;
    logic                 frame_end;

    assign row_end   = (beam_q.h == H_LAST);
    assign frame_end = row_end && (beam_q.v == V_LAST);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            beam_q        <= '0;
            frame_start_o <= 1'b0;
        end else begin
            // pulse lines up with the beam arriving at 0,0
            frame_start_o <= frame_end;
            if (row_end) begin
                beam_q.h <= '0;
                if (frame_end) begin
                    beam_q.v <= '0;
                end else begin
                    beam_q.v <= beam_q.v + 1'b1;
                end
            end else begin
                beam_q.h <= beam_q.h + 1'b1;
            end
        end
    end

    assign beam_o = beam_q;

    // pixel never runs past the row
    a_h_in_range: assert property (@(posedge clk) disable iff (!rst_n_i)
        int'(beam_q.h) < H_TOTAL)
        else $error("beam pixel counter out of range");

endmodule

// ==== source/copper_exec.sv ====
// copper fetch, decode and execute engine, runs the program once per frame and writes registers
`timescale 1ns/100ps

module copper_exec #(
    parameter int AWIDTH = 10
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 enable_i,
    input  logic                 frame_start_i,
    input  video_pkg::beam_pos_t beam_i,
    output logic [AWIDTH-1:0]    mem_addr_o,
    input  logic [15:0]          even_i,
    input  logic [15:0]          odd_i,
    output copper_pkg::reg_wr_t  reg_wr_o,
    output logic [AWIDTH-1:0]    pc_o,
    output logic                 running_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_DECODE,
        ST_WAIT
    } state_e;

    state_e             state_q;
    state_e             state_d;
    logic [AWIDTH-1:0]  pc_q;
    logic [AWIDTH-1:0]  pc_d;
    copper_pkg::instr_t instr;
    logic               beam_past;

    // both halves read the same index, even word on top
    assign instr = {even_i, odd_i};

    // past the target: later line, or same line with pixel reached
    assign beam_past = (16'(beam_i.v) > instr.op_a) ||
                       ((16'(beam_i.v) == instr.op_a) && (14'(beam_i.h) >= instr.op_b));

    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;
        if (!enable_i) begin
            // disabled, park until enabled and a new frame
            state_d = ST_IDLE;
        end else if (frame_start_i) begin
            // every frame restarts at 0, finished or not
            state_d = ST_FETCH;
            pc_d    = '0;
        end else begin
            case (state_q)
                ST_FETCH: begin
                    // address goes out now, word arrives next cycle
                    state_d = ST_DECODE;
                end
                ST_DECODE: begin
                    case (instr.opcode)
                        copper_pkg::COP_WAIT: begin
                            if (beam_past) begin
                                state_d = ST_FETCH;
                                pc_d    = pc_q + AWIDTH'(1);
                            end else begin
                                state_d = ST_WAIT;
                            end
                        end
                        copper_pkg::COP_MOVE: begin
                            // write goes out this cycle
                            state_d = ST_FETCH;
                            pc_d    = pc_q + AWIDTH'(1);
                        end
                        copper_pkg::COP_JUMP: begin
                            state_d = ST_FETCH;
                            pc_d    = instr.op_a[AWIDTH-1:0];
                        end
                        default: begin
                            // END, done until the next frame
                            state_d = ST_IDLE;
                        end
                    endcase
                end
                ST_WAIT: begin
                    // pc unchanged so the memory keeps showing this WAIT
                    if (beam_past) begin
                        state_d = ST_FETCH;
                        pc_d    = pc_q + AWIDTH'(1);
                    end
                end
                default: begin
                    // idle, only frame_start gets us out
                    state_d = ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            pc_q    <= '0;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
        end
    end

    // memory follows the program counter
    assign mem_addr_o = pc_q;

    // one write per MOVE, in its decode cycle
    always_comb begin
        reg_wr_o.valid = (state_q == ST_DECODE) && (instr.opcode == copper_pkg::COP_MOVE);
        reg_wr_o.addr  = instr.op_b[7:0];
        reg_wr_o.data  = instr.op_a;
    end

    // status back to the host
    assign pc_o      = pc_q;
    assign running_o = (state_q != ST_IDLE);

    // a MOVE write lasts one cycle, the next fetch follows right after
    a_move_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        reg_wr_o.valid && enable_i |=> (state_q == ST_FETCH) && !reg_wr_o.valid)
        else $error("register write held past its MOVE decode");

endmodule

// ==== source/copper_apb.sv ====
// APB slave of the copper, loads the program and holds the control and status registers
`timescale 1ns/100ps

module copper_apb #(
    parameter int AWIDTH = 10
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  copper_pkg::apb_req_t apb_i,
    output copper_pkg::apb_rsp_t apb_o,
    output logic                 enable_o,
    input  logic [AWIDTH-1:0]    pc_i,
    input  logic                 running_i,
    output logic                 even_wr_en_o,
    output logic                 odd_wr_en_o,
    output logic [AWIDTH-1:0]    prog_addr_o,
    output logic [15:0]          even_data_o,
    output logic [15:0]          odd_data_o
);

    // program window, one 32-bit word per instruction
    localparam int PROG_END = int'(copper_pkg::PROG_BASE) + 4 * (2**AWIDTH);

    logic access;
    logic hit_ctrl;
    logic hit_status;
    logic hit_prog;
    logic prog_wr;
    logic ctrl_q;

    // no wait states, every access phase completes
    assign access     = apb_i.psel && apb_i.penable;
    assign hit_ctrl   = (apb_i.paddr == copper_pkg::CTRL_ADDR);
    assign hit_status = (apb_i.paddr == copper_pkg::STATUS_ADDR);
    assign hit_prog   = (int'(apb_i.paddr) >= int'(copper_pkg::PROG_BASE)) &&
                        (int'(apb_i.paddr) < PROG_END);

    // control register, bit 0 enable
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ctrl_q <= 1'b0;
        end else if (access && apb_i.pwrite && hit_ctrl) begin
            ctrl_q <= apb_i.pwdata[0];
        end
    end

    assign enable_o = ctrl_q;

    // program writes go to both halves at once, in the access cycle
    assign prog_wr      = access && apb_i.pwrite && hit_prog;
    assign even_wr_en_o = prog_wr;
    assign odd_wr_en_o  = prog_wr;
    assign prog_addr_o  = apb_i.paddr[AWIDTH+1:2];
    assign even_data_o  = apb_i.pwdata[31:16];
    assign odd_data_o   = apb_i.pwdata[15:0];

    always_comb begin
        apb_o.prdata  = '0;
        apb_o.pready  = 1'b1;
        // anything outside the map
        apb_o.pslverr = access && !(hit_ctrl || hit_status || hit_prog);
        // program range reads back as 0
        if (access && !apb_i.pwrite) begin
            if (hit_ctrl) begin
                apb_o.prdata[0] = ctrl_q;
            end else if (hit_status) begin
                apb_o.prdata[15:4] = 12'(pc_i);
                apb_o.prdata[0]    = running_i;
            end
        end
    end

    // access phase is always preceded by a setup phase
    a_apb_setup: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(apb_i.penable) |-> $past(apb_i.psel))
        else $error("APB penable without a setup phase");

endmodule

// ==== source/copper_top.sv ====
// copper subsystem top, ties the APB slave, beam counter, engine and program memory together
`timescale 1ns/100ps

module copper_top #(
    parameter int AWIDTH  = 10,
    parameter int H_TOTAL = 800,
    parameter int V_TOTAL = 525
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  copper_pkg::apb_req_t apb_i,
    output copper_pkg::apb_rsp_t apb_o,
    output copper_pkg::reg_wr_t  reg_wr_o,
    output video_pkg::beam_pos_t beam_o
);

    // host side
    logic              enable;
    logic [AWIDTH-1:0] pc;
    logic              running;
    logic              even_wr_en;
    logic              odd_wr_en;
    logic [AWIDTH-1:0] prog_addr;
    logic [15:0]       even_wdata;
    logic [15:0]       odd_wdata;

    // copper side
    logic [AWIDTH-1:0] mem_addr;
    logic [15:0]       even_rdata;
    logic [15:0]       odd_rdata;
    logic              frame_start;

    copper_apb #(
        .AWIDTH (AWIDTH)
    ) u_apb (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .apb_i        (apb_i),
        .apb_o        (apb_o),
        .enable_o     (enable),
        .pc_i         (pc),
        .running_i    (running),
        .even_wr_en_o (even_wr_en),
        .odd_wr_en_o  (odd_wr_en),
        .prog_addr_o  (prog_addr),
        .even_data_o  (even_wdata),
        .odd_data_o   (odd_wdata)
    );

    beam_counter #(
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL)
    ) u_beam (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .beam_o        (beam_o),
        .frame_start_o (frame_start)
    );

    copper_exec #(
        .AWIDTH (AWIDTH)
    ) u_exec (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .enable_i      (enable),
        .frame_start_i (frame_start),
        .beam_i        (beam_o),
        .mem_addr_o    (mem_addr),
        .even_i        (even_rdata),
        .odd_i         (odd_rdata),
        .reg_wr_o      (reg_wr_o),
        .pc_o          (pc),
        .running_o     (running)
    );

    // operand A half
    copper_mem #(
        .AWIDTH (AWIDTH),
        .EVEN   (1'b1)
    ) mem_even (
        .clk       (clk),
        .rd_addr_i (mem_addr),
        .rd_data_o (even_rdata),
        .wr_en_i   (even_wr_en),
        .wr_addr_i (prog_addr),
        .wr_data_i (even_wdata)
    );

    // operand B and opcode half
    copper_mem #(
        .AWIDTH (AWIDTH),
        .EVEN   (1'b0)
    ) mem_odd (
        .clk       (clk),
        .rd_addr_i (mem_addr),
        .rd_data_o (odd_rdata),
        .wr_en_i   (odd_wr_en),
        .wr_addr_i (prog_addr),
        .wr_data_i (odd_wdata)
    );

endmodule

// ==== testbench/copper_tb_cases.svh ====
// program and expected write tables for the copper testbench, included inside the testbench module

localparam int NUM_ROWS = 4;

// row columns: first word, word count, random words after the program,
// frames to watch, first expected write, writes per frame
row_t row_tab [NUM_ROWS] = '{
    '{8'd0,  8'd0, 8'd0, 8'd2, 8'd0, 8'd0},
    '{8'd0,  8'd4, 8'd0, 8'd2, 8'd0, 8'd3},
    '{8'd4,  8'd7, 8'd0, 8'd2, 8'd3, 8'd3},
    '{8'd11, 8'd5, 8'd3, 8'd2, 8'd6, 8'd2}
};

// word columns: operand A, operand B, opcode
// rows load from index 0, so jump targets are row relative
logic [31:0] prog_tab [16] = '{
    {16'h1234, 14'h010, copper_pkg::COP_MOVE},
    {16'habcd, 14'h011, copper_pkg::COP_MOVE},
    {16'h0f0f, 14'h020, copper_pkg::COP_MOVE},
    {16'h0000, 14'h000, copper_pkg::COP_END},
    // waits at line 3 pixel 20, line 3 pixel 40, line 9 pixel 5
    {16'd3,    14'd20,  copper_pkg::COP_WAIT},
    {16'h0001, 14'h030, copper_pkg::COP_MOVE},
    {16'd3,    14'd40,  copper_pkg::COP_WAIT},
    {16'h0002, 14'h031, copper_pkg::COP_MOVE},
    {16'd9,    14'd5,   copper_pkg::COP_WAIT},
    {16'h0003, 14'h032, copper_pkg::COP_MOVE},
    {16'h0000, 14'h000, copper_pkg::COP_END},
    // jump to 3 skips the 0x41 move
    {16'h1111, 14'h040, copper_pkg::COP_MOVE},
    {16'd3,    14'd0,   copper_pkg::COP_JUMP},
    {16'hdead, 14'h041, copper_pkg::COP_MOVE},
    {16'h2222, 14'h042, copper_pkg::COP_MOVE},
    {16'h0000, 14'h000, copper_pkg::COP_END}
};

// write columns: register address, data, line and pixel of the preceding WAIT
exp_wr_t exp_tab [8] = '{
    '{8'h10, 16'h1234, 10'd0, 11'd0},
    '{8'h11, 16'habcd, 10'd0, 11'd0},
    '{8'h20, 16'h0f0f, 10'd0, 11'd0},
    '{8'h30, 16'h0001, 10'd3, 11'd20},
    '{8'h31, 16'h0002, 10'd3, 11'd40},
    '{8'h32, 16'h0003, 10'd9, 11'd5},
    '{8'h40, 16'h1111, 10'd0, 11'd0},
    '{8'h42, 16'h2222, 10'd0, 11'd0}
};

// ==== testbench/copper_tb.sv ====
// testbench for the copper subsystem, loads table programs over APB and checks every register write
`timescale 1ns/100ps

module copper_tb;

    localparam int AWIDTH       = 10;
    localparam int H_TOTAL      = 64;
    localparam int V_TOTAL      = 16;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int APB_TIMEOUT  = 16;

    // table row, points into the word and write lists
    typedef struct packed {
        logic [7:0] first_word;
        logic [7:0] n_words;
        logic [7:0] n_fill;
        logic [7:0] frames;
        logic [7:0] first_wr;
        logic [7:0] n_wr;
    } row_t;

    // expected write plus the beam point it may not come before
    typedef struct packed {
        logic [7:0]         addr;
        logic [15:0]        data;
        video_pkg::beam_v_t line;
        video_pkg::beam_h_t pixel;
    } exp_wr_t;

    // write as seen on the DUT output
    typedef struct packed {
        logic [15:0]          frame;
        video_pkg::beam_pos_t beam;
        copper_pkg::reg_wr_t  wr;
    } seen_wr_t;

    logic                 clk;
    logic                 rst_n_i;
    copper_pkg::apb_req_t apb_req;
    copper_pkg::apb_rsp_t apb_rsp;
    copper_pkg::reg_wr_t  reg_wr;
    video_pkg::beam_pos_t beam;
    seen_wr_t             seen_q [$];
    bit                   capture_on;
    int                   frame_cnt;

    `include "copper_tb_cases.svh"

    copper_top #(
        .AWIDTH  (AWIDTH),
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL)
    ) dut0 (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .apb_i    (apb_req),
        .apb_o    (apb_rsp),
        .reg_wr_o (reg_wr),
        .beam_o   (beam)
    );

    always #4 clk = ~clk;

    // falling edge sampling, outputs settled by then
    // frame count steps on the 0,0 cycle, which is the frame start cycle
    always @(negedge clk) begin
        if (beam.h == '0 && beam.v == '0) begin
            frame_cnt = frame_cnt + 1;
        end
        if (capture_on && reg_wr.valid) begin
            seen_q.push_back(seen_wr_t'{16'(frame_cnt), beam, reg_wr});
        end
    end

    task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s, got %0h expected %0h", $time, what, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s did not happen in time", what);
        $display("CHECKS FAILED");
        $fatal(1, "stopped on a timeout");
    endtask

    // one transfer, setup then access phase
    // response taken at the falling edge of the access cycle
    task automatic apb_access(input logic write, input logic [15:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk);
        while (!apb_rsp.pready) begin
            waited++;
            if (waited > APB_TIMEOUT) begin
                report_timeout("APB pready");
            end
            @(negedge clk);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [15:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        check_equal(err, 1'b0, $sformatf("PSLVERR on write to %0h", addr));
    endtask

    task automatic apb_read(input logic [15:0] addr, output logic [31:0] rdata, output logic err);
        apb_access(1'b0, addr, 32'd0, rdata, err);
    endtask

    task automatic wait_frame_start();
        int waited;
        waited = 0;
        do begin
            waited++;
            if (waited > FRAME_CYCLES + 8) begin
                report_timeout("frame start");
            end
            @(posedge clk);
            #1;
        end while (beam.h != '0 || beam.v != '0);
    endtask

    // returns one cycle after the n-th frame start from now
    task automatic wait_frames(input int n);
        int target;
        int waited;
        target = frame_cnt + n;
        waited = 0;
        while (frame_cnt < target) begin
            waited++;
            if (waited > (n + 1) * FRAME_CYCLES) begin
                report_timeout($sformatf("%0d frame starts", n));
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_row(input int r);
        row_t        row;
        exp_wr_t     exp;
        seen_wr_t    got;
        logic [31:0] rnd;
        int          base;
        row = row_tab[r];
        apb_write(copper_pkg::CTRL_ADDR, 32'd0);
        for (int w = 0; w < row.n_words; w++) begin
            apb_write(copper_pkg::PROG_BASE + 16'(4 * w), prog_tab[row.first_word + w]);
        end
        // junk moves behind END
        for (int f = 0; f < row.n_fill; f++) begin
            rnd = $urandom();
            apb_write(copper_pkg::PROG_BASE + 16'(4 * (row.n_words + f)),
                      {rnd[31:16], 6'd0, rnd[7:0], copper_pkg::COP_MOVE});
        end
        seen_q.delete();
        capture_on = 1'b1;
        apb_write(copper_pkg::CTRL_ADDR, 32'd1);
        base = frame_cnt;
        wait_frames(int'(row.frames) + 1);
        capture_on = 1'b0;
        check_equal(seen_q.size(), int'(row.frames) * int'(row.n_wr),
                    $sformatf("row %0d write count", r));
        for (int f = 0; f < row.frames; f++) begin
            for (int k = 0; k < row.n_wr; k++) begin
                got = seen_q[f * row.n_wr + k];
                exp = exp_tab[row.first_wr + k];
                check_equal(got.frame, 16'(base + 1 + f), $sformatf("row %0d write %0d frame", r, k));
                check_equal(got.wr.addr, exp.addr, $sformatf("row %0d write %0d address", r, k));
                check_equal(got.wr.data, exp.data, $sformatf("row %0d write %0d data", r, k));
                // later line, or same line with the pixel reached
                check_equal((got.beam.v > exp.line) ||
                            (got.beam.v == exp.line && got.beam.h >= exp.pixel), 1'b1,
                            $sformatf("row %0d write %0d before its WAIT target", r, k));
            end
        end
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;
        void'($urandom(27));
        clk        = 1'b0;
        rst_n_i    = 1'b0;
        apb_req    = '0;
        capture_on = 1'b0;
        frame_cnt  = 0;
        repeat (10) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        // control register readback and the unmapped hole
        apb_write(copper_pkg::CTRL_ADDR, 32'd1);
        apb_read(copper_pkg::CTRL_ADDR, rdata, err);
        check_equal(rdata, 32'd1, "CTRL readback after enable");
        apb_write(copper_pkg::CTRL_ADDR, 32'd0);
        apb_read(copper_pkg::CTRL_ADDR, rdata, err);
        check_equal(rdata, 32'd0, "CTRL readback after disable");
        apb_read(16'h0800, rdata, err);
        check_equal(err, 1'b1, "PSLVERR at 0x800");

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        // a late WAIT keeps the engine busy while STATUS is read
        apb_write(copper_pkg::CTRL_ADDR, 32'd0);
        apb_write(copper_pkg::PROG_BASE, {16'd8, 14'd0, copper_pkg::COP_WAIT});
        apb_write(copper_pkg::PROG_BASE + 16'd4, {16'h5555, 14'h050, copper_pkg::COP_MOVE});
        apb_write(copper_pkg::PROG_BASE + 16'd8, {16'h0000, 14'h000, copper_pkg::COP_END});
        apb_write(copper_pkg::CTRL_ADDR, 32'd1);
        wait_frame_start();
        apb_read(copper_pkg::STATUS_ADDR, rdata, err);
        // running, pc held at 0 by the WAIT
        check_equal(rdata, 32'h0000_0001, "STATUS while waiting");
        seen_q.delete();
        capture_on = 1'b1;
        apb_write(copper_pkg::CTRL_ADDR, 32'd0);
        apb_read(copper_pkg::STATUS_ADDR, rdata, err);
        check_equal(rdata[0], 1'b0, "running after disable");
        wait_frames(2);
        capture_on = 1'b0;
        check_equal(seen_q.size(), 0, "register writes while disabled");

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+testbench
source/copper_pkg.sv
source/video_pkg.sv
source/copper_mem.sv
source/beam_counter.sv
source/copper_exec.sv
source/copper_apb.sv
source/copper_top.sv
testbench/copper_tb.sv

// ==== Bender.yml ====
package:
  name: copper

sources:
  - files:
      - source/copper_pkg.sv
      - source/video_pkg.sv
      - source/copper_mem.sv
      - source/beam_counter.sv
      - source/copper_exec.sv
      - source/copper_apb.sv
      - source/copper_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/copper_tb.sv
